// File: tb.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/mem_req_router.sv
rtl/sram_bank.sv
rtl/mem_rsp_merge.sv
rtl/mem_subsys_top.sv
dv/mem_chk.sv
dv/mem_scoreboard.sv
dv/mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := mem_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+100
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/mem_tb.sv
// Testbench top. Traffic is random from a fixed seed and stops after a fixed cycle budget
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_tb;

  import mem_pkg::*;

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_CYCLES     = 2000;                              // Random traffic cycles
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 100;
  localparam int WIN_BITS       = 12;                                // 4 KiB window
  localparam logic [ADDR_W-1:0] WIN_BASE = `MEM_BASE;

  logic     clk;
  logic     rst;
  mem_req_t req;
  mem_rsp_t rsp;

  int rsp_count;       // Responses seen by the scoreboard
  int mismatch_errs;
  int timing_errs;
  int cycles;          // Free-running cycle count for the watchdog

  mem_subsys_top dut0 (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
  );

  mem_scoreboard sb0 (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .rsp           (rsp),
    .rsp_count     (rsp_count),
    .mismatch_errs (mismatch_errs),
    .timing_errs   (timing_errs)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  // Watchdog that ends a hung run
  initial begin
    wait (cycles >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // About 40% reads, 40% writes and 20% idles with 10% of addresses off the window
  function automatic mem_req_t random_req(input logic [ADDR_W-1:0] last_addr);
    mem_req_t    r;
    int unsigned pick;
    pick    = $urandom_range(99);
    r.wdata = $urandom();
    r.wmask = 4'($urandom());
    if (pick < 40) r.op = MEM_READ;
    else if (pick < 80) r.op = MEM_WRITE;
    else r.op = MEM_IDLE;
    pick = $urandom_range(99);
    if (pick < 10) begin
      r.addr = $urandom();
      if (r.addr[ADDR_W-1:WIN_BITS] == WIN_BASE[ADDR_W-1:WIN_BITS]) begin
        r.addr[ADDR_W-1] = ~r.addr[ADDR_W-1];   // Push it out of the window
      end
    end else if (pick < 35) begin
      r.addr = last_addr;                       // Same word again for read-after-write hits
    end else begin
      r.addr = WIN_BASE | $urandom_range(4095);
    end
    return r;
  endfunction

  initial begin : stimulus
    logic [ADDR_W-1:0] last_addr;
    mem_req_t          nxt;
    int                total;
    void'($urandom(96388));
    rst       = 1'b1;
    req       = '0;                             // Idle op
    last_addr = WIN_BASE;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    repeat (NUM_CYCLES) begin
      @(posedge clk);
      nxt = random_req(last_addr);
      if (nxt.addr[ADDR_W-1:WIN_BITS] == WIN_BASE[ADDR_W-1:WIN_BITS]) last_addr = nxt.addr;
      req <= nxt;
    end
    @(posedge clk);
    req <= '0;
    repeat (3) @(posedge clk);                  // Drain the last response
    @(negedge clk);
    #1;                                         // Past the scoreboard's falling-edge sample
    total = mismatch_errs + timing_errs + dut0.u_chk.assert_errs;
    $display("Checked %0d responses: %0d mismatches, %0d timing errors, %0d assertion failures",
             rsp_count, mismatch_errs, timing_errs, dut0.u_chk.assert_errs);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: dv/mem_scoreboard.sv
// Response checker with a byte-valid shadow memory. Samples on the falling edge
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_scoreboard (
  input  logic               clk,
  input  logic               rst,
  input  mem_pkg::mem_req_t  req,
  input  mem_pkg::mem_rsp_t  rsp,
  output int                 rsp_count,
  output int                 mismatch_errs,
  output int                 timing_errs
);

  import mem_pkg::*;

  localparam int WIN_BITS = 12;                      // 4 KiB window
  localparam logic [31:0] WIN_BASE = `MEM_BASE;

  // Expected response of one request
  typedef struct packed {
    logic        is_write;
    logic        err;
    logic [3:0]  cmp_mask;   // Bytes that are compared
    logic [31:0] data;
  } exp_rsp_t;

  logic [31:0] shadow     [0:1023];  // Word image of the whole window
  logic [3:0]  shadow_vld [0:1023];  // Bytes written so far
  exp_rsp_t    exp_q [$];            // At most one entry in flight
  int          n_rsp;
  int          n_mis;
  int          n_tim;

  assign rsp_count     = n_rsp;
  assign mismatch_errs = n_mis;
  assign timing_errs   = n_tim;

  function automatic logic [31:0] byte_mask(input logic [3:0] m);
    logic [31:0] bm;
    for (int i = 0; i < 4; i++) bm[8*i +: 8] = {8{m[i]}};
    return bm;
  endfunction

  // Model the request and queue what the DUT must return
  task automatic push_expected(input mem_req_t r);
    exp_rsp_t   e;
    logic [9:0] w;
    e          = '0;
    e.is_write = (r.op == MEM_WRITE);
    w          = r.addr[11:2];                           // Low two bits ignored
    if (r.addr[31:WIN_BITS] != WIN_BASE[31:WIN_BITS]) begin
      e.err      = 1'b1;                                 // Shadow left alone
      e.cmp_mask = 4'hF;
    end else if (r.op == MEM_WRITE) begin
      for (int i = 0; i < 4; i++) begin
        if (r.wmask[i]) begin
          shadow[w][8*i +: 8] = r.wdata[8*i +: 8];
          shadow_vld[w][i]    = 1'b1;
        end
      end
      e.data     = r.wdata;                              // Echo
      e.cmp_mask = 4'hF;
    end else begin
      e.data     = shadow[w];
      e.cmp_mask = shadow_vld[w];                        // Unwritten bytes skipped
    end
    exp_q.push_back(e);
  endtask

  task automatic check_response();
    exp_rsp_t e;
    if (exp_q.size() == 0) begin
      if (rsp.valid) begin
        n_tim++;
        $display("Timing error at %0t: response without a request one cycle before", $time);
      end
    end else begin
      e = exp_q.pop_front();
      if (!rsp.valid) begin
        n_tim++;
        $display("Timing error at %0t: no response one cycle after a request", $time);
      end else begin
        n_rsp++;
        if (rsp.is_write !== e.is_write || rsp.err !== e.err ||
            ((rsp.data ^ e.data) & byte_mask(e.cmp_mask)) !== 32'h0) begin
          n_mis++;
          $display("MISMATCH at %0t: got wr=%0b err=%0b data=%h, %s wr=%0b err=%0b data=%h mask=%h",
                   $time, rsp.is_write, rsp.err, rsp.data, "expected",
                   e.is_write, e.err, e.data, e.cmp_mask);
        end
      end
    end
  endtask

  // Check last cycle's request first, then take this cycle's
  always @(negedge clk) begin
    if (rst) begin
      exp_q.delete();
      for (int k = 0; k < 1024; k++) shadow_vld[k] = 4'h0;
    end else begin
      check_response();
      if (req.op != MEM_IDLE) push_expected(req);
    end
  end

endmodule

// File: dv/mem_chk.sv
// Timing and reset properties of the response port bound into every mem_subsys_top
`timescale 1ns/1ns

module mem_chk (
  input logic               clk,
  input logic               rst,
  input mem_pkg::mem_req_t  req,
  input mem_pkg::mem_rsp_t  rsp
);

  import mem_pkg::*;

  int assert_errs;   // Failures, read by the testbench top

  a_rsp_next: assert property (@(posedge clk) disable iff (rst)
    (req.op != MEM_IDLE) |=> rsp.valid)
    else begin assert_errs++; $error("no response one cycle after a request"); end

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
    (req.op == MEM_IDLE) |=> !rsp.valid)
    else begin assert_errs++; $error("response after an idle cycle"); end

  // Error slots carry no data
  a_err_zero: assert property (@(posedge clk) disable iff (rst)
    (rsp.valid && rsp.err) |-> (rsp.data == '0))
    else begin assert_errs++; $error("error response with nonzero data"); end

  a_rst_quiet: assert property (@(posedge clk) (rst || $fell(rst)) |-> !rsp.valid)
    else begin assert_errs++; $error("response valid in or right after reset"); end

endmodule

bind mem_subsys_top mem_chk u_chk (
  .clk (clk),
  .rst (rst),
  .req (req),
  .rsp (rsp)
);

// File: rtl/mem_subsys_top.sv
// Banked memory top. Requests are single-cycle strobes with no back-pressure
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_subsys_top (
  input  logic               clk,
  input  logic               rst,
  input  mem_pkg::mem_req_t  req,
  output mem_pkg::mem_rsp_t  rsp
);

  import mem_pkg::*;

  bank_req_t [`MEM_NUM_BANKS-1:0] bank_req;  // Router to banks
  mem_rsp_t  [`MEM_NUM_BANKS-1:0] bank_rsp;  // Banks to merge
  logic                           req_err;   // Out-of-window strobe
  logic                           req_write; // Op kind for the error slot

  // Zero-latency decode
  mem_req_router u_router (
    .req       (req),
    .bank_req  (bank_req),
    .req_err   (req_err),
    .req_write (req_write)
  );

  // Identical interleaved banks
  for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
    sram_bank u_bank (
      .clk      (clk),
      .rst      (rst),
      .bank_req (bank_req[b]),
      .bank_rsp (bank_rsp[b])
    );
  end

  // Single response port
  mem_rsp_merge u_merge (
    .clk       (clk),
    .rst       (rst),
    .bank_rsp  (bank_rsp),
    .req_err   (req_err),
    .req_write (req_write),
    .rsp       (rsp)
  );

endmodule

// File: rtl/mem_rsp_merge.sv
// Response merge. At most one bank may respond per cycle and error responses carry zero data
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_rsp_merge (
  input  logic                                    clk,
  input  logic                                    rst,
  input  mem_pkg::mem_rsp_t [`MEM_NUM_BANKS-1:0]  bank_rsp,
  input  logic                                    req_err,
  input  logic                                    req_write,
  output mem_pkg::mem_rsp_t                       rsp
);

  import mem_pkg::*;

  logic     err_q;   // Error slot due this cycle
  logic     wr_q;    // Op kind of that slot
  mem_rsp_t or_rsp;  // OR of all bank responses

  // Match the one-cycle bank latency on the error path
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      err_q <= 1'b0;
      wr_q  <= 1'b0;
    end else begin
      err_q <= req_err;
      wr_q  <= req_write;
    end
  end

  // Idle banks drive all zeros so a plain OR selects
  always_comb begin
    or_rsp = '0;
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      or_rsp = mem_rsp_t'(or_rsp | bank_rsp[b]);
    end
  end

  // No bank was touched in an error slot
  always_comb begin
    if (err_q) begin
      rsp          = '0;
      rsp.valid    = 1'b1;
      rsp.is_write = wr_q;
      rsp.err      = 1'b1;
    end else begin
      rsp = or_rsp;
    end
  end

endmodule

// File: rtl/sram_bank.sv
// One SRAM bank with one-cycle latency. Array contents are not initialized or reset
`timescale 1ns/1ns
`include "mem_defs.svh"

module sram_bank (
  input  logic                clk,
  input  logic                rst,
  input  mem_pkg::bank_req_t  bank_req,
  output mem_pkg::mem_rsp_t   bank_rsp
);

  import mem_pkg::*;

  // Storage with one word per entry
  logic [DATA_W-1:0] mem [`MEM_BANK_WORDS];

  mem_op_e           op_q;     // Op of the request in flight
  logic [IDX_W-1:0]  idx_q;    // Word it addressed
  logic [DATA_W-1:0] wdata_q;  // Write data for the echo

  // Valid op cleared by reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      op_q <= MEM_IDLE;
    end else begin
      op_q <= bank_req.op;
    end
  end

  // Payload held only while a request is present
  always_ff @(posedge clk) begin
    if (bank_req.op != MEM_IDLE) begin
      idx_q   <= bank_req.idx;
      wdata_q <= bank_req.wdata;
    end
  end

  // Masked write commits on the request edge
  always_ff @(posedge clk) begin
    if (bank_req.op == MEM_WRITE) begin
      for (int i = 0; i < MASK_W; i++) begin
        if (bank_req.wmask[i]) begin
          mem[bank_req.idx][8*i +: 8] <= bank_req.wdata[8*i +: 8];
        end
      end
    end
  end

  // Response cycle
  // Read sees the array after the write from the previous edge
  always_comb begin
    bank_rsp          = '0;
    bank_rsp.valid    = (op_q != MEM_IDLE);
    bank_rsp.is_write = (op_q == MEM_WRITE);
    case (op_q)
      MEM_READ:  bank_rsp.data = mem[idx_q];
      MEM_WRITE: bank_rsp.data = wdata_q;   // Echo of the write data
      default:   bank_rsp.data = '0;        // Zero keeps the merge OR clean
    endcase
  end

endmodule

// File: rtl/mem_req_router.sv
// Combinational request decode. Low two address bits are ignored and idle requests never error
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_req_router (
  input  mem_pkg::mem_req_t                        req,
  output mem_pkg::bank_req_t [`MEM_NUM_BANKS-1:0]  bank_req,
  output logic                                     req_err,
  output logic                                     req_write
);

  import mem_pkg::*;

  // Window base as a full-width constant for slicing
  localparam logic [ADDR_W-1:0] WIN_BASE = `MEM_BASE;

  logic              active;    // Request present this cycle
  logic              in_win;    // Address falls inside the window
  logic [BANK_W-1:0] bank_sel;  // Interleave bank
  logic [IDX_W-1:0]  word_idx;  // Word inside that bank

  assign active = (req.op != MEM_IDLE);

  // Upper bits must match the base exactly
  assign in_win = (req.addr[ADDR_W-1:WIN_LSB] == WIN_BASE[ADDR_W-1:WIN_LSB]);

  // Address fields from the top are window, word index, bank and byte offset
  assign bank_sel = req.addr[OFS_W +: BANK_W];
  assign word_idx = req.addr[OFS_W + BANK_W +: IDX_W];

  // Out-of-window access reaches no bank
  assign req_err = active && !in_win;

  // Op kind kept for the error response
  assign req_write = (req.op == MEM_WRITE);

  // Steer the op to the selected bank only
  always_comb begin
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      bank_req[b].op    = MEM_IDLE;      // Default quiet
      bank_req[b].idx   = word_idx;      // Payload fans out to all banks
      bank_req[b].wdata = req.wdata;
      bank_req[b].wmask = req.wmask;
      if (active && in_win && (bank_sel == BANK_W'(b))) begin
        bank_req[b].op = req.op;
      end
    end
  end

endmodule

// File: rtl/mem_pkg.sv
// Shared memory types that assume a power-of-two bank count and bank depth
`include "mem_defs.svh"

package mem_pkg;

  // Widths derived from the macros
  localparam int ADDR_W = `MEM_ADDR_W;
  localparam int DATA_W = `MEM_DATA_W;
  localparam int MASK_W = DATA_W / 8;                // One strobe per byte
  localparam int OFS_W = $clog2(MASK_W);             // Byte offset bits that are ignored
  localparam int BANK_W = $clog2(`MEM_NUM_BANKS);    // Bank select bits
  localparam int IDX_W = $clog2(`MEM_BANK_WORDS);    // Word index inside a bank
  localparam int WIN_LSB = OFS_W + BANK_W + IDX_W;   // First address bit above the window

  // Request operation
  typedef enum logic [1:0] {
    MEM_IDLE  = 2'd0,
    MEM_READ  = 2'd1,
    MEM_WRITE = 2'd2
  } mem_op_e;

  // External request valid for one cycle when op is not idle
  typedef struct packed {
    mem_op_e             op;
    logic [ADDR_W-1:0]   addr;   // Byte address
    logic [DATA_W-1:0]   wdata;
    logic [MASK_W-1:0]   wmask;  // Byte write enables
  } mem_req_t;

  // Request as seen by one bank
  typedef struct packed {
    mem_op_e             op;     // Idle unless this bank is selected
    logic [IDX_W-1:0]    idx;    // Word within the bank
    logic [DATA_W-1:0]   wdata;
    logic [MASK_W-1:0]   wmask;
  } bank_req_t;

  // Response one cycle after its request
  typedef struct packed {
    logic                valid;
    logic                is_write;
    logic                err;    // Address outside the window
    logic [DATA_W-1:0]   data;   // Read data or echoed write data
  } mem_rsp_t;

endpackage

// File: rtl/mem_defs.svh
// Memory window macros. Bank count and words per bank must be powers of two
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Byte address width of the request port
`define MEM_ADDR_W 32

// Word width with one mask bit per byte
`define MEM_DATA_W 32

// Word-interleaved banks with address bits 3:2 picking the bank
`define MEM_NUM_BANKS 4

// Words per bank with address bits 11:4 picking the word
`define MEM_BANK_WORDS 256

// Window base aligned to the 4 KiB window size
`define MEM_BASE 32'h8000_0000

`endif
